/* run_sim.sh */
#!/bin/sh
# Build and run the vector XIF testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_vec_xif -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vec_xif > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
exit 1

/* sim/tb_vec_xif_tasks.svh */
// Testbench helpers for value checks and XIF request driving

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got %h expected %h", name, got, exp);
    error_count++;
  end
endtask

// Inputs change a short time after the rising edge
task automatic next_drive_slot();
  @(posedge clk_i);
  #2;
endtask

task automatic offer_instr(input logic [31:0] instr, input logic [ID_W-1:0] id,
                           output logic acc, output logic wb, output logic [1:0] rr);
  next_drive_slot();
  req.issue_valid  = 1'b1;
  req.issue_instr  = instr;
  req.issue_hartid = '0;
  req.issue_id     = id;
  @(negedge clk_i);
  acc = resp.issue_accept;
  wb  = resp.issue_writeback;
  rr  = resp.issue_register_read;
  next_drive_slot();
  req.issue_valid = 1'b0;
endtask

task automatic send_regs(input logic [ID_W-1:0] id, input logic [31:0] rs1,
                         input logic [31:0] rs2);
  next_drive_slot();
  req.register_valid    = 1'b1;
  req.register_id       = id;
  req.register_rs       = {rs2, rs1};
  req.register_rs_valid = 2'b11;
  next_drive_slot();
  req.register_valid = 1'b0;
endtask

task automatic send_commit(input logic [ID_W-1:0] id, input logic kill);
  next_drive_slot();
  req.commit_valid = 1'b1;
  req.commit_id    = id;
  req.commit_kill  = kill;
  next_drive_slot();
  req.commit_valid = 1'b0;
  req.commit_kill  = 1'b0;
endtask

task automatic wait_issue_ready();
  do @(negedge clk_i); while (!resp.issue_ready);
endtask

/* sim/tb_vec_xif.sv */
// Testbench for the vector XIF issue front end with a stimulus table and scoreboard
`timescale 1ns/1ns
`default_nettype none

module tb_vec_xif
  import xif_pkg::*;
;

  localparam int NUM_ROWS       = 15;
  localparam int TIMEOUT_CYCLES = (NUM_ROWS + 1) * 40 + 10;
  localparam logic [1:0] ACT_NONE   = 2'd0;
  localparam logic [1:0] ACT_COMMIT = 2'd1;
  localparam logic [1:0] ACT_KILL   = 2'd2;

  typedef struct packed {
    logic [31:0]     instr;
    logic [ID_W-1:0] id;
    logic [31:0]     rs1;
    logic [31:0]     rs2;
    logic [1:0]      act;
    logic            exp_acc;
    logic            exp_disp;
  } row_t;

  typedef struct packed {
    logic [31:0]        instr;
    logic [ID_W-1:0]    id;
    logic [31:0]        rs1;
    logic [31:0]        rs2;
    logic               cfg;
    logic [VTYPE_W-1:0] vt;
  } disp_t;

  logic               clk_i;
  logic               rst_ni;
  x_req_t             req;
  x_resp_t            resp;
  instr_pack_t        instr_o;
  logic               instr_valid_o;
  logic               instr_ready_i;
  logic [VTYPE_W-1:0] vtype_o;

  row_t        rows [NUM_ROWS];
  disp_t       exp_q [$];
  int          error_count = 0;
  int          failed_tests = 0;
  integer      seed = 32'h25bc;
  logic        vt_pending = 1'b0;
  logic [7:0]  vt_expected;
  logic        hold_pending = 1'b0;
  instr_pack_t held;

  `include "tb_vec_xif_tasks.svh"

  vec_xif_top u_vec_xif_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .xif_req_i     (req),
    .xif_resp_o    (resp),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .vtype_o       (vtype_o)
  );

  function automatic logic [31:0] enc_vsetvli(input logic [7:0] vt);
    return {4'b0000, vt, 5'd2, 3'b111, 5'd1, 7'b1010111};
  endfunction

  function automatic logic [31:0] enc_vsetvl();
    return {7'b1000000, 5'd3, 5'd2, 3'b111, 5'd1, 7'b1010111};
  endfunction

  function automatic logic [31:0] enc_arith(input logic [2:0] f3);
    return {7'b0000001, 5'd4, 5'd2, f3, 5'd1, 7'b1010111};
  endfunction

  function automatic row_t make_row(input logic [31:0] instr, input logic [3:0] id,
                                    input logic [31:0] rs1, input logic [31:0] rs2,
                                    input logic [1:0] act, input logic acc, input logic disp);
    return '{instr, id, rs1, rs2, act, acc, disp};
  endfunction

  // Expected {writeback, register_read} of an accepted OP-V word
  function automatic logic [2:0] expected_decode(input logic [31:0] instr);
    if (instr[14:12] == 3'b111) return instr[31] ? 3'b111 : 3'b101;
    if (instr[14:12] == 3'b100 || instr[14:12] == 3'b110) return 3'b001;
    return 3'b000;
  endfunction

  function automatic logic is_vsetvl(input logic [31:0] instr);
    return instr[6:0] == 7'b1010111 && instr[14:12] == 3'b111 && instr[31:25] == 7'b1000000;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    #2;
    instr_ready_i <= ($random(seed) & 3) != 0;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout, the DUT stopped responding before all tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  // Dispatch monitor sampled mid-cycle
  always @(negedge clk_i) begin
    disp_t e;
    if (rst_ni) begin
      if (vt_pending) check_val("vtype_o", 32'(vtype_o), 32'(vt_expected));
      vt_pending = 1'b0;
      if (hold_pending) begin
        check_val("instr_valid_o", 32'(instr_valid_o), 32'd1);
        check_val("instr_o.instr", instr_o.instr, held.instr);
        check_val("instr_o.id", 32'(instr_o.id), 32'(held.id));
        check_val("instr_o.rs1", instr_o.rs1, held.rs1);
        check_val("instr_o.rs2", instr_o.rs2, held.rs2);
      end
      hold_pending = instr_valid_o && !instr_ready_i;
      held = instr_o;
      if (instr_valid_o && instr_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected dispatch of instruction %h", instr_o.instr);
          error_count++;
        end else begin
          e = exp_q.pop_front();
          check_val("instr_o.instr", instr_o.instr, e.instr);
          check_val("instr_o.id", 32'(instr_o.id), 32'(e.id));
          check_val("instr_o.rs1", instr_o.rs1, e.rs1);
          check_val("instr_o.rs2", instr_o.rs2, e.rs2);
          vt_pending  = e.cfg;
          vt_expected = e.vt;
        end
      end
    end
  end

  initial begin
    logic acc;
    logic wb;
    logic [1:0] rr;
    int errs_before;
    req = '0;
    instr_ready_i = 1'b0;
    rst_ni = 1'b0;
    rows[0]  = make_row(32'h00208033, 4'd0, 32'h0, 32'h0, ACT_NONE, 1'b0, 1'b0);
    rows[1]  = make_row(enc_arith(3'b000), 4'd1, 32'h1, 32'h2, ACT_COMMIT, 1'b1, 1'b1);
    rows[2]  = make_row(enc_arith(3'b100), 4'd2, 32'h11111111, 32'h3, ACT_COMMIT, 1'b1, 1'b1);
    rows[3]  = make_row(enc_vsetvli(8'h12), 4'd3, 32'h40, 32'h4, ACT_COMMIT, 1'b1, 1'b1);
    rows[4]  = make_row(enc_arith(3'b110), 4'd4, 32'h5, 32'h6, ACT_NONE, 1'b1, 1'b0);
    rows[5]  = make_row(enc_arith(3'b010), 4'd5, 32'h7, 32'h8, ACT_KILL, 1'b1, 1'b0);
    // Reserved element width in the speculative vtype blocks arithmetic
    rows[6]  = make_row(enc_vsetvli(8'h25), 4'd6, 32'h9, 32'ha, ACT_NONE, 1'b1, 1'b0);
    rows[7]  = make_row(enc_arith(3'b000), 4'd7, 32'hb, 32'hc, ACT_KILL, 1'b0, 1'b0);
    rows[8]  = make_row(enc_arith(3'b000), 4'd8, 32'hd, 32'he, ACT_COMMIT, 1'b1, 1'b1);
    rows[9]  = make_row(enc_vsetvl(), 4'd9, 32'h20, 32'hcafe00a5, ACT_COMMIT, 1'b1, 1'b1);
    rows[10] = make_row(enc_arith(3'b000), 4'd10, 32'hf, 32'h10, ACT_NONE, 1'b0, 1'b0);
    rows[11] = make_row(enc_vsetvli(8'h03), 4'd11, 32'h80, 32'h11, ACT_COMMIT, 1'b1, 1'b1);
    rows[12] = make_row(enc_arith(3'b100), 4'd12, 32'h12345678, 32'h0, ACT_COMMIT, 1'b1, 1'b1);
    rows[13] = make_row(enc_vsetvl(), 4'd13, 32'h10, 32'h0000011c, ACT_COMMIT, 1'b1, 1'b1);
    rows[14] = make_row(enc_arith(3'b000), 4'd14, 32'h13, 32'h14, ACT_COMMIT, 1'b1, 1'b1);
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("instr_valid_o", 32'(instr_valid_o), 32'd0);
    check_val("issue_ready", 32'(resp.issue_ready), 32'd1);
    check_val("register_ready", 32'(resp.register_ready), 32'd1);
    check_val("vtype_o", 32'(vtype_o), 32'd0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      errs_before = error_count;
      wait_issue_ready();
      offer_instr(rows[i].instr, rows[i].id, acc, wb, rr);
      check_val("issue_accept", 32'(acc), 32'(rows[i].exp_acc));
      if (acc) begin
        check_val("issue_writeback", 32'(wb), 32'(expected_decode(rows[i].instr) >> 2));
        check_val("issue_register_read", 32'(rr), 32'(expected_decode(rows[i].instr) & 3));
        send_regs(rows[i].id, rows[i].rs1, rows[i].rs2);
      end
      if (acc && rows[i].act == ACT_COMMIT) begin
        if (rows[i].exp_disp) begin
          exp_q.push_back('{rows[i].instr, rows[i].id, rows[i].rs1, rows[i].rs2,
                            rows[i].instr[14:12] == 3'b111,
                            rows[i].instr[31] ? rows[i].rs2[7:0] : rows[i].instr[27:20]});
        end
        send_commit(rows[i].id, 1'b0);
      end else if (rows[i].act == ACT_KILL) begin
        send_commit(rows[i].id, 1'b1);
      end
      if (acc && is_vsetvl(rows[i].instr)) begin
        check_val("issue_ready", 32'(resp.issue_ready), 32'd0);
        wait_issue_ready();
        check_val("pending_dispatches", 32'(exp_q.size()), 32'd0);
      end
      if (error_count != errs_before) failed_tests++;
      $display("Row %0d finished with %0d errors", i, error_count - errs_before);
    end

    // Fill all four entries without commits
    errs_before = error_count;
    do @(negedge clk_i); while (exp_q.size() != 0 || !resp.issue_ready);
    for (int k = 0; k < XIF_BUF_DEPTH; k++) begin
      offer_instr(enc_arith(3'b000), ID_W'(k), acc, wb, rr);
      check_val("issue_accept", 32'(acc), 32'd1);
    end
    @(negedge clk_i);
    check_val("issue_ready", 32'(resp.issue_ready), 32'd0);
    exp_q.push_back('{enc_arith(3'b000), 4'd0, 32'h0, 32'h0, 1'b0, 8'h0});
    send_commit(4'd0, 1'b0);
    wait_issue_ready();
    check_val("pending_dispatches", 32'(exp_q.size()), 32'd0);
    send_commit(4'd1, 1'b1);
    wait_issue_ready();
    if (error_count != errs_before) failed_tests++;
    $display("Full buffer test finished with %0d errors", error_count - errs_before);

    do @(negedge clk_i); while (exp_q.size() != 0);
    repeat (3) @(negedge clk_i);
    $display("Tests run %0d, tests failed %0d, errors %0d", NUM_ROWS + 1, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/vec_csr_unit.sv */
// Vector CSR unit holding the committed vtype and feeding the sync record
`timescale 1ns/1ns
`default_nettype none

module vec_csr_unit
  import xif_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire instr_pack_t instr_i,
  input  wire logic        instr_valid_i,
  input  wire logic        instr_ready_i,
  output csr_sync_t        csr_sync_o
);

  logic               dispatch;
  logic               is_cfg;
  logic               is_vsetvli;
  logic               is_vsetvl;
  logic [VTYPE_W-1:0] vtype_d;
  logic [VTYPE_W-1:0] vtype_q;

  assign dispatch = instr_valid_i & instr_ready_i;

  assign is_cfg     = (instr_i.instr[6:0] == OPC_OP_V) && (instr_i.instr[14:12] == F3_OPCFG);
  assign is_vsetvli = is_cfg && !instr_i.instr[31];
  assign is_vsetvl  = is_cfg && (instr_i.instr[31:25] == F7_VSETVL);

  always_comb begin
    vtype_d = vtype_q;
    if (dispatch) begin
      if (is_vsetvli) begin
        vtype_d = instr_i.instr[VTYPE_IMM_LSB +: VTYPE_W];
      end else if (is_vsetvl) begin
        // Register form, vtype sits in the low bits of rs2
        vtype_d = instr_i.rs2[VTYPE_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vtype_q <= '0;
    end else begin
      vtype_q <= vtype_d;
    end
  end

  always_comb begin
    csr_sync_o       = '0;
    csr_sync_o.vtype = vtype_q;
  end

endmodule

`default_nettype wire

/* source/vec_xif_top.sv */
// Vector coprocessor issue front end joining the XIF handler and the CSR unit
`timescale 1ns/1ns
`default_nettype none

module vec_xif_top
  import xif_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire x_req_t        xif_req_i,
  output x_resp_t            xif_resp_o,
  output instr_pack_t        instr_o,
  output logic               instr_valid_o,
  input  wire logic          instr_ready_i,
  output logic [VTYPE_W-1:0] vtype_o
);

  csr_sync_t csr_sync;

  xif_issue_handler u_issue_handler (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .xif_req_i     (xif_req_i),
    .xif_resp_o    (xif_resp_o),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .csr_sync_i    (csr_sync)
  );

  vec_csr_unit u_csr_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_i       (instr_o),
    .instr_valid_i (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .csr_sync_o    (csr_sync)
  );

  assign vtype_o = csr_sync.vtype;

endmodule

`default_nettype wire

/* source/xif_issue_handler.sv */
// XIF issue handler with pre-decode, speculative buffering and vtype sync control
`timescale 1ns/1ns
`default_nettype none

module xif_issue_handler
  import xif_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire x_req_t      xif_req_i,
  output x_resp_t          xif_resp_o,
  output instr_pack_t      instr_o,
  output logic             instr_valid_o,
  input  wire logic        instr_ready_i,
  input  wire csr_sync_t   csr_sync_i
);

  typedef enum logic {
    SYNC_NORMAL,
    SYNC_WAIT_EMPTY
  } sync_state_e;

  sync_state_e  sync_state_d, sync_state_q;

  logic         commit_ok;
  logic         commit_kill;
  logic         issue_ready;
  logic         push_instr;
  logic         predec_valid;
  logic         csr_sync_valid;
  logic         buffer_full;
  logic         buffer_empty;
  logic         buf_has_spec_csr;
  predec_resp_t predec_resp;
  instr_pack_t  instr_to_buffer;

  assign commit_ok   = xif_req_i.commit_valid & ~xif_req_i.commit_kill;
  assign commit_kill = xif_req_i.commit_valid & xif_req_i.commit_kill;

  // No new issue while full or while waiting to resync vtype
  assign issue_ready  = ~buffer_full & (sync_state_q != SYNC_WAIT_EMPTY);
  assign predec_valid = xif_req_i.issue_valid & issue_ready & ~commit_kill;
  assign push_instr   = predec_valid & predec_resp.accept;

  // Operands are filled in later by the register interface
  always_comb begin
    instr_to_buffer               = '0;
    instr_to_buffer.instr         = xif_req_i.issue_instr;
    instr_to_buffer.hartid        = xif_req_i.issue_hartid;
    instr_to_buffer.id            = xif_req_i.issue_id;
    instr_to_buffer.writeback     = predec_resp.writeback;
    instr_to_buffer.register_read = predec_resp.register_read;
    instr_to_buffer.is_spec_csr   = predec_resp.spec_mod | predec_resp.spec_mod_reg;
  end

  always_comb begin
    xif_resp_o                     = '0;
    xif_resp_o.issue_ready         = issue_ready;
    xif_resp_o.issue_accept        = predec_resp.accept;
    xif_resp_o.issue_writeback     = predec_resp.writeback;
    xif_resp_o.issue_register_read = predec_resp.register_read;
    xif_resp_o.register_ready      = 1'b1;
  end

  xif_pre_decoder u_pre_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_i          (xif_req_i.issue_instr),
    .valid_i          (predec_valid),
    .csr_sync_valid_i (csr_sync_valid),
    .csr_sync_i       (csr_sync_i),
    .resp_o           (predec_resp)
  );

  xif_spec_ring_buffer #(
    .dtype (instr_pack_t)
  ) u_spec_buffer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .push_i           (push_instr),
    .id_i             (xif_req_i.issue_id),
    .data_i           (instr_to_buffer),
    .register_valid_i (xif_req_i.register_valid),
    .reg_id_i         (xif_req_i.register_id),
    .rs_i             (xif_req_i.register_rs),
    .rs_valid_i       (xif_req_i.register_rs_valid),
    .commit_i         (commit_ok),
    .commit_id_i      (xif_req_i.commit_id),
    .flush_i          (commit_kill),
    .ready_i          (instr_ready_i),
    .valid_o          (instr_valid_o),
    .data_o           (instr_o),
    .full_o           (buffer_full),
    .empty_o          (buffer_empty),
    .keep_spec_csr_o  (buf_has_spec_csr)
  );

  // Kill rolls the speculative vtype back, a vsetvl waits for its own dispatch
  always_comb begin
    sync_state_d   = sync_state_q;
    csr_sync_valid = 1'b0;
    case (sync_state_q)
      SYNC_WAIT_EMPTY: begin
        if (buffer_empty) begin
          csr_sync_valid = 1'b1;
          sync_state_d   = SYNC_NORMAL;
        end
      end
      default: begin
        if (commit_kill) begin
          // Buffered vtype writers must drain before the committed copy is right
          if (buf_has_spec_csr) sync_state_d = SYNC_WAIT_EMPTY;
          else csr_sync_valid = 1'b1;
        end else if (push_instr && predec_resp.spec_mod_reg) begin
          sync_state_d = SYNC_WAIT_EMPTY;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_state_q <= SYNC_NORMAL;
    end else begin
      sync_state_q <= sync_state_d;
    end
  end

endmodule

`default_nettype wire

/* source/xif_pkg.sv */
// XIF package with the shared widths, opcodes and the request, response and buffer records
`default_nettype none

package xif_pkg;

  // Buffer and interface sizes
  localparam int unsigned XIF_BUF_DEPTH = 4;
  localparam int unsigned BUF_PTR_W     = $clog2(XIF_BUF_DEPTH);
  localparam int unsigned ID_W          = 4;
  localparam int unsigned HARTID_W      = 1;
  localparam int unsigned XLEN          = 32;
  localparam int unsigned VTYPE_W       = 8;

  // Vector encodings
  localparam logic [6:0] OPC_OP_V      = 7'b1010111;
  localparam logic [2:0] F3_OPCFG      = 3'b111;
  // Upper bits of vsetvl, bits 31:25
  localparam logic [6:0] F7_VSETVL     = 7'b1000000;
  // vsetvli carries its vtype at bit 20 and up
  localparam int unsigned VTYPE_IMM_LSB = 20;

  // Core to coprocessor
  typedef struct packed {
    logic                          issue_valid;
    logic [31:0]                   issue_instr;
    logic [HARTID_W-1:0]           issue_hartid;
    logic [ID_W-1:0]               issue_id;
    logic                          register_valid;
    logic [ID_W-1:0]               register_id;
    logic [1:0][XLEN-1:0]          register_rs;
    logic [1:0]                    register_rs_valid;
    logic                          commit_valid;
    logic [ID_W-1:0]               commit_id;
    logic                          commit_kill;
  } x_req_t;

  // Coprocessor to core
  typedef struct packed {
    logic       issue_ready;
    logic       issue_accept;
    logic       issue_writeback;
    logic [1:0] issue_register_read;
    logic       register_ready;
  } x_resp_t;

  // Pre-decoder answer for one offered instruction
  typedef struct packed {
    logic       accept;
    logic       writeback;
    logic [1:0] register_read;
    logic       spec_mod;
    logic       spec_mod_reg;
  } predec_resp_t;

  // One buffered instruction, operands filled in while it waits
  typedef struct packed {
    logic [31:0]         instr;
    logic [HARTID_W-1:0] hartid;
    logic [ID_W-1:0]     id;
    logic                writeback;
    logic [1:0]          register_read;
    logic [XLEN-1:0]     rs1;
    logic [XLEN-1:0]     rs2;
    logic                is_spec_csr;
  } instr_pack_t;

  // Committed CSR state handed back to the pre-decoder
  typedef struct packed {
    logic [VTYPE_W-1:0] vtype;
  } csr_sync_t;

endpackage

`default_nettype wire

/* source/xif_pre_decoder.sv */
// Vector pre-decoder that answers XIF offers and tracks the speculative vtype
`timescale 1ns/1ns
`default_nettype none

module xif_pre_decoder
  import xif_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic [31:0]   instr_i,
  input  wire logic          valid_i,
  input  wire logic          csr_sync_valid_i,
  input  wire csr_sync_t     csr_sync_i,
  output predec_resp_t       resp_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [VTYPE_W-1:0] vtype_q;
  logic               vsew_rsvd;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // SEW of 128 and above is reserved, vtype layout is {vma, vta, vsew, vlmul}
  assign vsew_rsvd = vtype_q[5];

  always_comb begin
    resp_o = '0;
    if (opcode == OPC_OP_V) begin
      if (funct3 == F3_OPCFG) begin
        if (!instr_i[31]) begin
          // vsetvli, new vtype comes from the immediate
          resp_o.accept        = 1'b1;
          resp_o.writeback     = 1'b1;
          resp_o.register_read = 2'b01;
          resp_o.spec_mod      = 1'b1;
        end else if (instr_i[31:25] == F7_VSETVL) begin
          // vsetvl, vtype is only known once rs2 arrives
          resp_o.accept        = 1'b1;
          resp_o.writeback     = 1'b1;
          resp_o.register_read = 2'b11;
          resp_o.spec_mod_reg  = 1'b1;
        end
      end else begin
        // Arithmetic needs a legal element width
        resp_o.accept = ~vsew_rsvd;
        // OPIVX and OPMVX take a scalar in rs1
        if ((funct3 == 3'b100) || (funct3 == 3'b110)) begin
          resp_o.register_read = 2'b01;
        end
      end
    end
  end

  // Speculative vtype, a sync from the committed copy wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vtype_q <= '0;
    end else if (csr_sync_valid_i) begin
      vtype_q <= csr_sync_i.vtype;
    end else if (valid_i && resp_o.accept && resp_o.spec_mod) begin
      vtype_q <= instr_i[VTYPE_IMM_LSB +: VTYPE_W];
    end
  end

endmodule

`default_nettype wire

/* source/xif_spec_ring_buffer.sv */
// Speculative in-order ring buffer with operand fill, commit and kill
`timescale 1ns/1ns
`default_nettype none

module xif_spec_ring_buffer
  import xif_pkg::*;
#(
  parameter type dtype = instr_pack_t
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 push_i,
  input  wire logic [ID_W-1:0]      id_i,
  input  wire dtype                 data_i,
  input  wire logic                 register_valid_i,
  input  wire logic [ID_W-1:0]      reg_id_i,
  input  wire logic [1:0][XLEN-1:0] rs_i,
  input  wire logic [1:0]           rs_valid_i,
  input  wire logic                 commit_i,
  input  wire logic [ID_W-1:0]      commit_id_i,
  input  wire logic                 flush_i,
  input  wire logic                 ready_i,
  output logic                      valid_o,
  output dtype                      data_o,
  output logic                      full_o,
  output logic                      empty_o,
  output logic                      keep_spec_csr_o
);

  dtype                          mem_q [XIF_BUF_DEPTH];
  logic [XIF_BUF_DEPTH-1:0]      vld_q;
  logic [XIF_BUF_DEPTH-1:0]      cmt_q;
  logic [XIF_BUF_DEPTH-1:0][1:0] rs_ok_q;
  logic [BUF_PTR_W-1:0]          head_q;
  logic [BUF_PTR_W-1:0]          tail_q;
  logic [BUF_PTR_W:0]            cnt_q;

  logic                          do_push;
  logic                          do_pop;
  logic [1:0]                    head_need;
  logic [XIF_BUF_DEPTH-1:0]      pop_mask;
  logic [XIF_BUF_DEPTH-1:0]      keep_mask;
  logic [BUF_PTR_W:0]            n_keep;

  assign full_o  = (cnt_q == (BUF_PTR_W+1)'(XIF_BUF_DEPTH));
  assign empty_o = (cnt_q == '0);

  // Head leaves once committed and every operand it reads is in
  assign head_need = mem_q[head_q].register_read & ~rs_ok_q[head_q];
  assign valid_o   = vld_q[head_q] & cmt_q[head_q] & ~|head_need;
  assign data_o    = mem_q[head_q];

  assign do_pop   = valid_o & ready_i;
  assign do_push  = push_i & ~flush_i;
  assign pop_mask = XIF_BUF_DEPTH'(do_pop) << head_q;

  // Committed entries form a prefix from the head, a kill keeps only that prefix
  always_comb begin : flush_scan
    logic [BUF_PTR_W-1:0] idx;
    logic                 run;
    run       = 1'b1;
    n_keep    = '0;
    keep_mask = '0;
    for (int i = 0; i < XIF_BUF_DEPTH; i++) begin
      idx = head_q + BUF_PTR_W'(i);
      run = run & vld_q[idx] & cmt_q[idx];
      if (run) begin
        keep_mask[idx] = 1'b1;
        n_keep         = n_keep + 1'b1;
      end
    end
  end

  always_comb begin
    keep_spec_csr_o = 1'b0;
    for (int i = 0; i < XIF_BUF_DEPTH; i++) begin
      keep_spec_csr_o = keep_spec_csr_o | (vld_q[i] & mem_q[i].is_spec_csr);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      cnt_q   <= '0;
      vld_q   <= '0;
      cmt_q   <= '0;
      rs_ok_q <= '0;
    end else begin
      for (int i = 0; i < XIF_BUF_DEPTH; i++) begin
        if (vld_q[i] && commit_i && (mem_q[i].id == commit_id_i)) begin
          cmt_q[i] <= 1'b1;
        end
        if (vld_q[i] && register_valid_i && (mem_q[i].id == reg_id_i)) begin
          rs_ok_q[i] <= rs_ok_q[i] | rs_valid_i;
        end
      end
      if (do_pop) begin
        vld_q[head_q] <= 1'b0;
        head_q        <= head_q + 1'b1;
      end
      if (flush_i) begin
        vld_q  <= keep_mask & ~pop_mask;
        tail_q <= head_q + n_keep[BUF_PTR_W-1:0];
        cnt_q  <= n_keep - {{BUF_PTR_W{1'b0}}, do_pop};
      end else begin
        if (do_push) begin
          // Commit or registers may arrive in the same cycle as the offer
          vld_q[tail_q]   <= 1'b1;
          cmt_q[tail_q]   <= commit_i && (commit_id_i == id_i);
          rs_ok_q[tail_q] <= (register_valid_i && (reg_id_i == id_i)) ? rs_valid_i : 2'b00;
          tail_q          <= tail_q + 1'b1;
        end
        cnt_q <= cnt_q + {{BUF_PTR_W{1'b0}}, do_push} - {{BUF_PTR_W{1'b0}}, do_pop};
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < XIF_BUF_DEPTH; i++) begin
      if (vld_q[i] && register_valid_i && (mem_q[i].id == reg_id_i)) begin
        if (rs_valid_i[0]) mem_q[i].rs1 <= rs_i[0];
        if (rs_valid_i[1]) mem_q[i].rs2 <= rs_i[1];
      end
    end
    if (do_push) begin
      mem_q[tail_q] <= data_i;
      if (register_valid_i && (reg_id_i == id_i)) begin
        if (rs_valid_i[0]) mem_q[tail_q].rs1 <= rs_i[0];
        if (rs_valid_i[1]) mem_q[tail_q].rs2 <= rs_i[1];
      end
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+sim
source/xif_pkg.sv
source/xif_pre_decoder.sv
source/xif_spec_ring_buffer.sv
source/xif_issue_handler.sv
source/vec_csr_unit.sv
source/vec_xif_top.sv
sim/tb_vec_xif.sv
